//--- hdl/bringup_pkg.sv
// Bring-up monitor widths, vector types, timing defaults, report characters and scanner states
package bringup_pkg;

	// Sensed pins
	localparam int NUM_PINS = 16;

	typedef logic [NUM_PINS-1:0] pin_vec_t; // Raw levels or activity flags

	typedef logic [7:0] uart_byte_t;

	// Activity decay
	localparam int DECAY_W = 2;

	typedef logic [DECAY_W-1:0] decay_t;

	localparam decay_t DECAY_MAX = 2'd3; // Decay ticks a flag survives

	// Default periods in clock cycles, 12 MHz board clock
	localparam int unsigned CLOCKS_PER_BAUD  = 104;     // 115200 baud
	localparam int unsigned CLOCKS_PER_DEC   = 12000;   // 1 kHz
	localparam int unsigned CLOCKS_PER_SCAN  = 1200000; // 10 Hz
	localparam int unsigned CLOCKS_PER_DRIVE = 6000;    // Half period of tp9

	// Report line characters
	localparam uart_byte_t CHAR_ACTIVE = 8'h23; // '#'
	localparam uart_byte_t CHAR_QUIET  = 8'h2d; // '-'
	localparam uart_byte_t CHAR_CR     = 8'h0d;
	localparam uart_byte_t CHAR_LF     = 8'h0a;

	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_SEND, // One pin character
		SCAN_WAIT,
		SCAN_EOL   // CR then LF
	} scan_state_t;

endpackage

//--- hdl/tick_gen.sv
// Free-running period divider with one-cycle tick and toggling square wave
module tick_gen #(
	parameter int unsigned CLOCKS_PER_TICK = 16
) (
	input  logic clock,
	input  logic arst_n_i,
	output logic tick_o,
	output logic square_o
);

	localparam int unsigned CNT_W = (CLOCKS_PER_TICK > 1) ? $clog2(CLOCKS_PER_TICK) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLOCKS_PER_TICK - 1);

	logic [CNT_W-1:0] cnt_q;
	logic wrap;

	assign wrap = (cnt_q == CNT_LAST);

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q    <= '0;
			tick_o   <= 1'b0;
			square_o <= 1'b0;
		end else begin
			tick_o   <= wrap;
			square_o <= square_o ^ wrap; // Half period is one tick period
			if (wrap) begin
				cnt_q <= '0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

endmodule

//--- hdl/pin_sensor_bank.sv
// Per-pin synchroniser, edge detector and decaying activity counter
module pin_sensor_bank import bringup_pkg::*; (
	input  logic     clock,
	input  logic     arst_n_i,
	input  pin_vec_t pins_i,
	input  logic     dec_i,
	output pin_vec_t active_o
);

	pin_vec_t sync_q1;
	pin_vec_t sync_q2;
	pin_vec_t prev_q;
	pin_vec_t pin_edge;
	decay_t   decay_q [NUM_PINS];

	// Two-flop synchroniser plus one stage of history
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			prev_q  <= '0;
		end else begin
			sync_q1 <= pins_i;
			sync_q2 <= sync_q1;
			prev_q  <= sync_q2;
		end
	end

	assign pin_edge = sync_q2 ^ prev_q; // Either polarity

	// An edge reloads, a decay tick counts down to zero
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < NUM_PINS; i++) begin
				decay_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_PINS; i++) begin
				if (pin_edge[i]) begin
					decay_q[i] <= DECAY_MAX; // Edge wins over a coincident decay tick
				end else if (dec_i && (decay_q[i] != '0)) begin
					decay_q[i] <= decay_q[i] - 1'b1;
				end
			end
		end
	end

	// Alive while the counter has not run out
	always_comb begin
		for (int i = 0; i < NUM_PINS; i++) begin
			active_o[i] = |decay_q[i];
		end
	end

endmodule

//--- hdl/bringup_scanner.sv
// Scanner FSM that snapshots activity flags and streams one report line per scan tick
module bringup_scanner import bringup_pkg::*; (
	input  logic       clock,
	input  logic       arst_n_i,
	input  logic       scan_i,
	input  pin_vec_t   active_i,
	input  logic       hold_i,
	output logic       write_o,
	output uart_byte_t data_o
);

	localparam int PIN_W = $clog2(NUM_PINS);
	localparam int IDX_W = $clog2(NUM_PINS + 3);

	// Line positions past the pin characters
	localparam logic [IDX_W-1:0] IDX_CR   = IDX_W'(NUM_PINS);
	localparam logic [IDX_W-1:0] IDX_LF   = IDX_W'(NUM_PINS + 1);
	localparam logic [IDX_W-1:0] IDX_DONE = IDX_W'(NUM_PINS + 2);

	scan_state_t      state_q;
	pin_vec_t         snap_q;
	logic [IDX_W-1:0] idx_q;
	logic             frame_start;
	logic             sending;

	assign frame_start = (state_q == SCAN_IDLE) && scan_i;
	assign sending     = (state_q == SCAN_SEND) || (state_q == SCAN_EOL);

	// Only strobe when the UART is free
	assign write_o = sending && !hold_i;

	always_comb begin
		if (state_q == SCAN_SEND) begin
			data_o = snap_q[idx_q[PIN_W-1:0]] ? CHAR_ACTIVE : CHAR_QUIET;
		end else if (idx_q == IDX_LF) begin
			data_o = CHAR_LF;
		end else begin
			data_o = CHAR_CR;
		end
	end

	// Flags frozen for the whole line
	always_ff @(posedge clock) begin
		if (frame_start) begin
			snap_q <= active_i;
		end
	end

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= SCAN_IDLE;
			idx_q   <= '0;
		end else begin
			case (state_q)
				SCAN_IDLE: begin
					if (scan_i) begin
						idx_q   <= '0;
						state_q <= SCAN_SEND;
					end
				end
				SCAN_SEND, SCAN_EOL: begin
					if (write_o) begin
						idx_q   <= idx_q + 1'b1;
						state_q <= SCAN_WAIT;
					end
				end
				SCAN_WAIT: begin
					// One cycle so busy from the UART is visible again
					if (idx_q == IDX_DONE) begin
						state_q <= SCAN_IDLE;
					end else if (idx_q >= IDX_CR) begin
						state_q <= SCAN_EOL;
					end else begin
						state_q <= SCAN_SEND;
					end
				end
				default: begin
					state_q <= SCAN_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hdl/uart_tx.sv
// 8N1 serial transmitter with busy flag
module uart_tx import bringup_pkg::*; #(
	parameter int unsigned CLOCKS_PER_BAUD = bringup_pkg::CLOCKS_PER_BAUD
) (
	input  logic       clock,
	input  logic       arst_n_i,
	input  logic       write_i,
	input  uart_byte_t data_i,
	output logic       busy_o,
	output logic       tx_o
);

	localparam int unsigned BAUD_W = (CLOCKS_PER_BAUD > 1) ? $clog2(CLOCKS_PER_BAUD) : 1;
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLOCKS_PER_BAUD - 1);
	localparam logic [3:0] BIT_STOP = 4'd9;

	logic [BAUD_W-1:0] baud_q;
	logic [3:0]        bit_q; // 0 start, 1 to 8 data, 9 stop
	uart_byte_t        shift_q;
	logic              accept;
	logic              baud_end;
	logic              next_bit;

	assign accept   = write_i && !busy_o;
	assign baud_end = (baud_q == BAUD_LAST);
	assign next_bit = busy_o && baud_end && (bit_q != BIT_STOP);

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_o <= 1'b0;
			tx_o   <= 1'b1; // Line idles high
			baud_q <= '0;
			bit_q  <= '0;
		end else if (!busy_o) begin
			if (write_i) begin
				busy_o <= 1'b1;
				tx_o   <= 1'b0; // Start bit
				baud_q <= '0;
				bit_q  <= '0;
			end
		end else if (baud_end) begin
			baud_q <= '0;
			if (bit_q == BIT_STOP) begin
				busy_o <= 1'b0;
			end else begin
				tx_o  <= shift_q[0];
				bit_q <= bit_q + 1'b1;
			end
		end else begin
			baud_q <= baud_q + 1'b1;
		end
	end

	// LSB first, ones shifted in supply the stop bit
	always_ff @(posedge clock) begin
		if (accept) begin
			shift_q <= data_i;
		end else if (next_bit) begin
			shift_q <= {1'b1, shift_q[7:1]};
		end
	end

endmodule

//--- hdl/bringup_boundary.sv
// Bring-up monitor top level with driver pin, pin sensors, line scanner and UART
module bringup_boundary import bringup_pkg::*; #(
	parameter int unsigned SCAN_CLOCKS  = CLOCKS_PER_SCAN,
	parameter int unsigned DEC_CLOCKS   = CLOCKS_PER_DEC,
	parameter int unsigned DRIVE_CLOCKS = CLOCKS_PER_DRIVE,
	parameter int unsigned BAUD_CLOCKS  = CLOCKS_PER_BAUD
) (
	input  logic     clock,
	input  logic     arst_n_i,
	input  pin_vec_t pins_i,
	output logic     tp9_o,
	output logic     uart_tx_o
);

	logic       dec_tick;
	logic       scan_tick;
	pin_vec_t   pin_active;
	logic       uart_write;
	uart_byte_t uart_data;
	logic       uart_busy;

	// Square wave on tp9 for a probe or loopback wire
	tick_gen #(
		.CLOCKS_PER_TICK(DRIVE_CLOCKS)
	) i_drive_tick (
		.clock   (clock),
		.arst_n_i(arst_n_i),
		.tick_o  (),
		.square_o(tp9_o)
	);

	tick_gen #(
		.CLOCKS_PER_TICK(DEC_CLOCKS) // Slower than the driver
	) i_dec_tick (
		.clock   (clock),
		.arst_n_i(arst_n_i),
		.tick_o  (dec_tick),
		.square_o()
	);

	tick_gen #(
		.CLOCKS_PER_TICK(SCAN_CLOCKS)
	) i_scan_tick (
		.clock   (clock),
		.arst_n_i(arst_n_i),
		.tick_o  (scan_tick),
		.square_o()
	);

	pin_sensor_bank i_pin_sensor_bank (
		.clock   (clock),
		.arst_n_i(arst_n_i),
		.pins_i  (pins_i),
		.dec_i   (dec_tick),
		.active_o(pin_active)
	);

	bringup_scanner i_bringup_scanner (
		.clock   (clock),
		.arst_n_i(arst_n_i),
		.scan_i  (scan_tick),
		.active_i(pin_active),
		.hold_i  (uart_busy),
		.write_o (uart_write),
		.data_o  (uart_data)
	);

	uart_tx #(
		.CLOCKS_PER_BAUD(BAUD_CLOCKS)
	) i_uart_tx (
		.clock   (clock),
		.arst_n_i(arst_n_i),
		.write_i (uart_write),
		.data_i  (uart_data),
		.busy_o  (uart_busy),
		.tx_o    (uart_tx_o)
	);

endmodule

//--- verification/tb_clock_gen.sv
// Testbench clock and power-on reset source
module tb_clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic clock_o,
	output logic arst_n_o
);

	initial begin
		clock_o = 1'b0;
		forever #(PERIOD / 2) clock_o = ~clock_o;
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_o);
		arst_n_o <= 1'b1; // Released on a rising edge
	end

endmodule

//--- verification/bringup_boundary_asserts.sv
// Bound concurrent assertions on the scanner to UART handshake and the serial line
module bringup_boundary_asserts (
	input logic clock,
	input logic arst_n_i,
	input logic scan_i,
	input logic write_i,
	input logic busy_i,
	input logic tx_i
);

	int unsigned fail_count = 0; // Read by the testbench
	logic scan_seen_q;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			scan_seen_q <= 1'b0;
		end else if (scan_i) begin
			scan_seen_q <= 1'b1;
		end
	end

	// Strobe only into an idle UART, which then turns busy
	write_when_free: assert property (@(posedge clock) disable iff (!arst_n_i)
		write_i |-> !busy_i ##1 busy_i)
	else begin
		fail_count++;
		$error("Write strobe while the UART was busy or not taken by the UART");
	end

	single_cycle_write: assert property (@(posedge clock) disable iff (!arst_n_i)
		write_i |=> !write_i)
	else begin
		fail_count++;
		$error("Write strobe held for two cycles");
	end

	idle_line_high: assert property (@(posedge clock) disable iff (!arst_n_i)
		!busy_i |-> tx_i)
	else begin
		fail_count++;
		$error("Serial line low while the UART was idle");
	end

	// Start bit right after the accepted write
	start_after_write: assert property (@(posedge clock) disable iff (!arst_n_i)
		write_i |=> !tx_i)
	else begin
		fail_count++;
		$error("No start bit in the cycle after a write");
	end

	quiet_before_scan: assert property (@(posedge clock) disable iff (!arst_n_i)
		!scan_seen_q |-> tx_i)
	else begin
		fail_count++;
		$error("Serial line left idle before the first scan tick");
	end

endmodule

bind bringup_boundary bringup_boundary_asserts i_boundary_asserts (
	.clock   (clock),
	.arst_n_i(arst_n_i),
	.scan_i  (scan_tick),
	.write_i (uart_write),
	.busy_i  (uart_busy),
	.tx_i    (uart_tx_o)
);

//--- verification/bringup_boundary_tb.sv
// Testbench for the bring-up monitor with serial line decoder, per-test checks and watchdog
module bringup_boundary_tb import bringup_pkg::*; ();

	localparam int BAUD_CLOCKS    = 4;
	localparam int DEC_CLOCKS     = 200;
	localparam int SCAN_CLOCKS    = 1000;
	localparam int DRIVE_CLOCKS   = 10;
	localparam int LINE_LEN       = NUM_PINS + 2;
	localparam int TIMEOUT_CYCLES = 12 * SCAN_CLOCKS;
	localparam logic [31:0] SEED  = 32'h03ba4796;

	// Expected report characters
	localparam logic [7:0] EXP_ACTIVE = 8'h23;
	localparam logic [7:0] EXP_QUIET  = 8'h2d;
	localparam logic [7:0] EXP_CR     = 8'h0d;
	localparam logic [7:0] EXP_LF     = 8'h0a;

	logic       clock;
	logic       arst_n;
	pin_vec_t   pins_drv;
	pin_vec_t   pins;
	logic       loopback_en;
	logic       tp9_o;
	logic       uart_tx_o;
	logic [7:0] line_buf [LINE_LEN];
	logic [7:0] got_line [LINE_LEN];
	int         line_len;
	int         got_len;
	int         line_count;
	logic       byte_active;
	logic [31:0] rng_q;
	int         error_count;
	int         tests_run;
	int         tests_failed;
	int         cycle_count;

	tb_clock_gen #(
		.PERIOD      (20),
		.RESET_CYCLES(4)
	) i_tb_clock_gen (
		.clock_o (clock),
		.arst_n_o(arst_n)
	);

	// Loopback wire from tp9 into pin 15
	assign pins = loopback_en ? {tp9_o, pins_drv[NUM_PINS-2:0]} : pins_drv;

	bringup_boundary #(
		.SCAN_CLOCKS (SCAN_CLOCKS),
		.DEC_CLOCKS  (DEC_CLOCKS),
		.DRIVE_CLOCKS(DRIVE_CLOCKS),
		.BAUD_CLOCKS (BAUD_CLOCKS)
	) i_bringup_boundary (
		.clock    (clock),
		.arst_n_i (arst_n),
		.pins_i   (pins),
		.tp9_o    (tp9_o),
		.uart_tx_o(uart_tx_o)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Mid-bit sampling on falling edges
	task automatic receive_byte(output logic [7:0] data);
		logic [7:0] bits;
		@(negedge clock);
		while (uart_tx_o !== 1'b0) begin
			@(negedge clock);
		end
		byte_active = 1'b1;
		repeat (BAUD_CLOCKS / 2) @(negedge clock);
		assert (uart_tx_o === 1'b0) else begin
			error_count++;
			$display("Error: uart_tx_o start bit expected 0 received %h", uart_tx_o);
		end
		for (int i = 0; i < 8; i++) begin
			repeat (BAUD_CLOCKS) @(negedge clock);
			bits[i] = uart_tx_o;
		end
		repeat (BAUD_CLOCKS) @(negedge clock);
		assert (uart_tx_o === 1'b1) else begin
			error_count++;
			$display("Error: uart_tx_o stop bit expected 1 received %h", uart_tx_o);
		end
		byte_active = 1'b0;
		data = bits;
	endtask

	// Waits for a line whose frame starts after the call
	task automatic collect_fresh_line();
		int target;
		target = line_count + 1;
		if (byte_active || (line_len != 0)) begin
			target++;
		end
		wait (line_count >= target);
	endtask

	task automatic check_line(input pin_vec_t active);
		logic [7:0] expected;
		assert (got_len == LINE_LEN) else begin
			error_count++;
			$display("Report line had %0d characters instead of %0d", got_len, LINE_LEN);
		end
		for (int i = 0; i < LINE_LEN; i++) begin
			if (i < NUM_PINS) begin
				expected = active[i] ? EXP_ACTIVE : EXP_QUIET;
			end else if (i == NUM_PINS) begin
				expected = EXP_CR;
			end else begin
				expected = EXP_LF;
			end
			assert (got_line[i] == expected) else begin
				error_count++;
				$display("Error: uart_tx_o character %0d expected %h received %h",
					i, expected, got_line[i]);
			end
		end
	endtask

	task automatic toggle_pins(input pin_vec_t mask, input int cycles);
		int elapsed;
		int gap;
		elapsed = 0;
		while (elapsed < cycles) begin
			rng_q = lcg_next(rng_q);
			gap = 2 + int'(rng_q[25:24]); // Two to five cycles
			repeat (gap) @(posedge clock);
			pins_drv <= pins_drv ^ mask;
			elapsed += gap;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: FAILED with %0d errors", tests_run, name,
				error_count - errors_before);
		end
	endtask

	// Collects characters into lines ended by LF
	initial begin : uart_monitor
		logic [7:0] rx;
		line_len    = 0;
		got_len     = 0;
		line_count  = 0;
		byte_active = 1'b0;
		for (int i = 0; i < LINE_LEN; i++) begin
			got_line[i] = '0;
			line_buf[i] = '0;
		end
		wait (arst_n === 1'b1);
		forever begin
			receive_byte(rx);
			if (line_len < LINE_LEN) begin
				line_buf[line_len] = rx;
			end
			line_len++;
			if (rx == EXP_LF) begin
				got_line = line_buf;
				got_len    = line_len;
				line_len   = 0;
				line_count++;
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin : watchdog
		cycle_count = 0;
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles while waiting for a report line", cycle_count);
		$display("Regression failed");
		$finish;
	end

	initial begin : main_sequence
		pin_vec_t mask;
		int errors_before;
		pins_drv     = '0;
		loopback_en  = 1'b0;
		rng_q        = SEED;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		wait (arst_n === 1'b1);
		@(negedge clock);

		errors_before = error_count;
		assert (tp9_o === 1'b0) else begin
			error_count++;
			$display("Error: tp9_o after reset expected 0 received %h", tp9_o);
		end
		assert (uart_tx_o === 1'b1) else begin
			error_count++;
			$display("Error: uart_tx_o after reset expected 1 received %h", uart_tx_o);
		end
		repeat (SCAN_CLOCKS - 2) begin
			@(negedge clock);
			assert (uart_tx_o === 1'b1) else begin
				error_count++;
				$display("Serial line went low before the first scan tick");
			end
		end
		finish_test("reset and idle line", errors_before);

		errors_before = error_count;
		collect_fresh_line();
		check_line('0);
		finish_test("steady pins report quiet", errors_before);

		errors_before = error_count;
		rng_q = lcg_next(rng_q);
		mask = rng_q[31:16];
		if (mask == '0) begin
			mask = 16'h0001;
		end
		@(posedge clock);
		toggle_pins(mask, SCAN_CLOCKS);
		collect_fresh_line();
		check_line(mask);
		finish_test("toggled pins report active", errors_before);

		errors_before = error_count;
		repeat (2 * SCAN_CLOCKS) @(posedge clock);
		collect_fresh_line();
		check_line('0);
		finish_test("activity decays", errors_before);

		errors_before = error_count;
		@(posedge clock);
		loopback_en <= 1'b1;
		@(posedge clock);
		collect_fresh_line();
		check_line(16'h8000); // Only the looped-back pin
		finish_test("tp9 loopback on pin 15", errors_before);

		errors_before = error_count;
		assert (i_bringup_boundary.i_boundary_asserts.fail_count == 0) else begin
			error_count++;
			$display("Bound assertions failed %0d times",
				i_bringup_boundary.i_boundary_asserts.fail_count);
		end
		finish_test("handshake and framing assertions", errors_before);

		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- bringup_boundary.f
hdl/bringup_pkg.sv
hdl/tick_gen.sv
hdl/pin_sensor_bank.sv
hdl/bringup_scanner.sv
hdl/uart_tx.sv
hdl/bringup_boundary.sv
verification/tb_clock_gen.sv
verification/bringup_boundary_asserts.sv
verification/bringup_boundary_tb.sv

//--- Bender.yml
package:
  name: bringup_boundary

sources:
  - files:
      - hdl/bringup_pkg.sv
      - hdl/tick_gen.sv
      - hdl/pin_sensor_bank.sv
      - hdl/bringup_scanner.sv
      - hdl/uart_tx.sv
      - hdl/bringup_boundary.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/bringup_boundary_asserts.sv
      - verification/bringup_boundary_tb.sv
